// File: game_sender_top.f
+incdir+include
hw/sender_pkg.sv
hw/tetromino_render.sv
hw/bit_clock_gen.sv
hw/packet_sender.sv
hw/game_sender_top.sv
tests/game_sender_checker.sv
tests/game_sender_tb.sv

// File: hw/bit_clock_gen.sv
// Free running bit timer; bit_tick fires when the count is zero, right out of reset.
`timescale 1ns/100ps
`default_nettype none

`include "sender_config.svh"

module bit_clock_gen (
    input  logic clk,
    input  logic rst_n,
    output logic bit_tick,
    output logic serial_clk
);

    logic [$clog2(`SERIAL_DIV)-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            serial_clk <= 1'b0;
        end else begin
            if (cnt == `SERIAL_DIV - 1) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // one clock late, so the low half lines up with lane data updated at the tick.
            serial_clk <= (cnt >= `SERIAL_DIV / 2);
        end
    end

    assign bit_tick = (cnt == '0);                   // one clock in every SERIAL_DIV.

endmodule

`default_nettype wire

// File: hw/game_sender_top.sv
// Sender top level; req.piece is rendered with no latency and latched on transfer.
`timescale 1ns/100ps
`default_nettype none

`include "sender_config.svh"

module game_sender_top
    import sender_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  send_req_t               req,
    input  logic                    ack_valid,
    input  logic                    ack_seq,
    output logic                    serial_clk,
    output logic                    serial_hdr,
    output logic [`DATA_LANES-1:0]  serial_data,
    output logic                    seq_num
);

    piece_tiles_t tiles;
    logic         bit_tick;

    tetromino_render u_render (
        .piece (req.piece),
        .tiles (tiles)
    );

    bit_clock_gen u_bit_clk (
        .clk        (clk),
        .rst_n      (rst_n),
        .bit_tick   (bit_tick),
        .serial_clk (serial_clk)
    );

    packet_sender u_sender (
        .clk         (clk),
        .rst_n       (rst_n),
        .bit_tick    (bit_tick),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .tiles       (tiles),
        .ack_valid   (ack_valid),
        .ack_seq     (ack_seq),
        .serial_hdr  (serial_hdr),
        .serial_data (serial_data),
        .seq_num     (seq_num)
    );

endmodule

`default_nettype wire

// File: hw/packet_sender.sv
// Sends one frame per accepted request and then waits for a matching ack.
// A lost ack stalls the port until reset; there is no retransmission.
`timescale 1ns/100ps
`default_nettype none

`include "sender_config.svh"

module packet_sender
    import sender_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    bit_tick,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  send_req_t               req,
    input  piece_tiles_t            tiles,
    input  logic                    ack_valid,
    input  logic                    ack_seq,
    output logic                    serial_hdr,
    output logic [`DATA_LANES-1:0]  serial_data,
    output logic                    seq_num
);

    sender_state_e                          state;
    frame_t                                 frame;
    logic [`DATA_LANES-1:0][`LANE_BITS-1:0] lane_sr;
    logic [$clog2(`LANE_BITS+1)-1:0]        bit_cnt;
    logic                                   xfer;

    assign xfer = req_valid && req_ready;

    // frame as it would go out for the request on the port right now.
    always_comb begin
        frame.opcode  = req.opcode;
        frame.seq     = seq_num;
        frame.garbage = req.garbage;
        frame.tiles   = tiles;
        frame.pad     = '0;
    end

    // lane k takes frame bits 47-12k down to 36-12k, msb first.
    always_ff @(posedge clk) begin
        if (xfer) begin
            for (int k = 0; k < `DATA_LANES; k++) begin
                lane_sr[k] <= frame[`FRAME_BITS - 1 - `LANE_BITS * k -: `LANE_BITS];
            end
        end else if (state == st_shift && bit_tick) begin
            for (int k = 0; k < `DATA_LANES; k++) begin
                lane_sr[k] <= {lane_sr[k][`LANE_BITS-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            bit_cnt     <= '0;
            req_ready   <= 1'b1;
            serial_hdr  <= 1'b0;
            serial_data <= '0;
            seq_num     <= 1'b0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (xfer) begin
                        state     <= st_shift;
                        bit_cnt   <= '0;
                        req_ready <= 1'b0;           // held low until the ack comes back.
                    end
                end
                st_shift: begin
                    if (bit_tick) begin
                        if (bit_cnt == `LANE_BITS) begin
                            serial_hdr  <= 1'b0;     // last bit period is over.
                            serial_data <= '0;
                            state       <= st_wait_ack;
                        end else begin
                            serial_hdr <= 1'b1;
                            for (int k = 0; k < `DATA_LANES; k++) begin
                                serial_data[k] <= lane_sr[k][`LANE_BITS-1];
                            end
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                st_wait_ack: begin
                    // a stale or foreign sequence bit is simply dropped.
                    if (ack_valid && ack_seq == seq_num) begin
                        seq_num   <= ~seq_num;
                        req_ready <= 1'b1;
                        state     <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/sender_pkg.sv
// Types shared by the sender blocks. Tile coordinates are not range checked
// against the playfield, so an offset tile may lie outside it.
`default_nettype none

package sender_pkg;

    `include "sender_config.svh"

    typedef enum logic [2:0] {
        blank, i, o, t, j, l, s, z
    } tile_type_t;

    typedef enum logic [1:0] {
        north, east, south, west
    } orientation_t;                                 // one clockwise step per value.

    typedef enum logic [1:0] {
        msg_garbage, msg_ready, msg_lost, msg_piece
    } msg_opcode_t;

    typedef struct packed {
        logic [$clog2(`PLAYFIELD_ROWS)-1:0] row;     // 5 bits.
        logic [$clog2(`PLAYFIELD_COLS)-1:0] col;     // 4 bits.
    } tile_pos_t;

    typedef struct packed {
        tile_type_t                         piece_type;
        orientation_t                       orient;
        logic [$clog2(`PLAYFIELD_ROWS)-1:0] origin_row;
        logic [$clog2(`PLAYFIELD_COLS)-1:0] origin_col;
    } piece_t;

    typedef tile_pos_t [3:0] piece_tiles_t;

    typedef struct packed {
        msg_opcode_t opcode;
        logic [3:0]  garbage;                        // garbage lines sent to the peer.
        piece_t      piece;
    } send_req_t;

    typedef struct packed {
        msg_opcode_t  opcode;                        // bits 47:46.
        logic         seq;                           // bit 45, alternating per frame.
        logic [3:0]   garbage;
        piece_tiles_t tiles;                         // tile 3 sits in the upper bits.
        logic [4:0]   pad;                           // always zero.
    } frame_t;

    typedef enum logic [1:0] {
        st_idle, st_shift, st_wait_ack
    } sender_state_e;

endpackage

`default_nettype wire

// File: hw/tetromino_render.sv
// Spawn shapes follow the standard rotation system, row 0 at the top of the box.
// Offsets are added to the origin and wrap only at the coordinate width; no clipping.
`timescale 1ns/100ps
`default_nettype none

module tetromino_render
    import sender_pkg::*;
(
    input  piece_t       piece,
    output piece_tiles_t tiles
);

    // four (row, col) offsets of two bits each, tile 0 in the top nibble.
    logic [15:0] offs;

    always_comb begin
        unique case ({piece.piece_type, piece.orient})
            {i, north}: offs = 16'b01_00_01_01_01_10_01_11;
            {i, east}:  offs = 16'b00_10_01_10_10_10_11_10;
            {i, south}: offs = 16'b10_00_10_01_10_10_10_11;
            {i, west}:  offs = 16'b00_01_01_01_10_01_11_01;
            {o, north}, {o, east}, {o, south}, {o, west}:
                        offs = 16'b00_01_00_10_01_01_01_10;  // the square does not turn.
            {t, north}: offs = 16'b00_01_01_00_01_01_01_10;
            {t, east}:  offs = 16'b00_01_01_01_01_10_10_01;
            {t, south}: offs = 16'b01_00_01_01_01_10_10_01;
            {t, west}:  offs = 16'b00_01_01_00_01_01_10_01;
            {j, north}: offs = 16'b00_00_01_00_01_01_01_10;
            {j, east}:  offs = 16'b00_01_00_10_01_01_10_01;
            {j, south}: offs = 16'b01_00_01_01_01_10_10_10;
            {j, west}:  offs = 16'b00_01_01_01_10_00_10_01;
            {l, north}: offs = 16'b00_10_01_00_01_01_01_10;
            {l, east}:  offs = 16'b00_01_01_01_10_01_10_10;
            {l, south}: offs = 16'b01_00_01_01_01_10_10_00;
            {l, west}:  offs = 16'b00_00_00_01_01_01_10_01;
            {s, north}: offs = 16'b00_01_00_10_01_00_01_01;
            {s, east}:  offs = 16'b00_01_01_01_01_10_10_10;
            {s, south}: offs = 16'b01_01_01_10_10_00_10_01;
            {s, west}:  offs = 16'b00_00_01_00_01_01_10_01;
            {z, north}: offs = 16'b00_00_00_01_01_01_01_10;
            {z, east}:  offs = 16'b00_10_01_01_01_10_10_01;
            {z, south}: offs = 16'b01_00_01_01_10_01_10_10;
            {z, west}:  offs = 16'b00_01_01_00_01_01_10_00;
            default:    offs = 16'b0;                // blank puts all four tiles on the origin.
        endcase
    end

    always_comb begin
        for (int n = 0; n < 4; n++) begin
            tiles[n].row = piece.origin_row + {3'b000, offs[15 - 4 * n -: 2]};
            tiles[n].col = piece.origin_col + {2'b00, offs[13 - 4 * n -: 2]};
        end
    end

endmodule

`default_nettype wire

// File: include/sender_config.svh
// Frame format and serial timing constants of the game link sender.
// SERIAL_DIV must be even and at least 2; LANE_BITS must equal FRAME_BITS / DATA_LANES.
`ifndef SENDER_CONFIG_SVH
`define SENDER_CONFIG_SVH

// system clocks per serial bit period.
`define SERIAL_DIV 8

// playfield size; it sets the row and column widths of a tile position.
`define PLAYFIELD_ROWS 20
`define PLAYFIELD_COLS 10

// one header lane plus this many data lanes go out in parallel.
`define DATA_LANES 4

// frame length and the share of it carried by each data lane.
`define FRAME_BITS 48
`define LANE_BITS 12

`endif

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Iinclude -f game_sender_top.f \
    --top-module game_sender_tb -o sim_game_sender

status=0
./obj_dir/sim_game_sender > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then
    echo "simulation failed (exit status $status)"
    exit 1
fi
exit 0

// File: tests/game_sender_checker.sv
// Protocol assertions for packet_sender; attached by bind, so it sees the sender's ports.
`timescale 1ns/100ps
`default_nettype none

`include "sender_config.svh"

module game_sender_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   req_ready,
    input logic                   ack_valid,
    input logic                   ack_seq,
    input logic                   serial_hdr,
    input logic [`DATA_LANES-1:0] serial_data,
    input logic                   seq_num
);

    // the port is never free while a frame is on the lanes.
    hdr_blocks_ready: assert property (@(posedge clk) disable iff (!rst_n)
        serial_hdr |-> !req_ready)
        else $error("req_ready high during a frame");

    lanes_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        !serial_hdr |-> serial_data == '0)
        else $error("data lanes active outside a frame");

    // a toggle must follow a matching ack one clock earlier.
    seq_needs_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (seq_num != $past(seq_num)) |-> ($past(ack_valid) && $past(ack_seq) == $past(seq_num)))
        else $error("seq_num changed without a matching ack");

endmodule

bind packet_sender game_sender_checker u_checker (.*);

`default_nettype wire

// File: tests/game_sender_tb.sv
// Drives requests and acks from the stimulus file and rebuilds frames from the lanes.
// Sequence bits in the file are zero; the expected seq comes from a local toggling copy.
`timescale 1ns/100ps
`default_nettype none

`include "sender_config.svh"

module game_sender_tb
    import sender_pkg::*;
();

    localparam int NUM_TESTS = 10;
    localparam int WORDS     = 8;
    localparam int LIMIT     = NUM_TESTS * (14 * `SERIAL_DIV + 64) + 200;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    send_req_t              req;
    logic                   ack_valid;
    logic                   ack_seq;
    logic                   serial_clk;
    logic                   serial_hdr;
    logic [`DATA_LANES-1:0] serial_data;
    logic                   seq_num;

    logic [63:0]            stim [0:NUM_TESTS*WORDS-1];
    frame_t                 got_q[$];
    logic [0:`DATA_LANES-1][`LANE_BITS-1:0] mon_lane;
    int                     mon_bits;
    int                     frames_seen;
    int                     errors;
    int                     cycles;
    logic                   seq;
    logic                   pending;
    frame_t                 exp_frame;
    frame_t                 got_frame;
    string                  name;

    game_sender_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .ack_valid   (ack_valid),
        .ack_seq     (ack_seq),
        .serial_clk  (serial_clk),
        .serial_hdr  (serial_hdr),
        .serial_data (serial_data),
        .seq_num     (seq_num)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the link made no progress within %0d cycles", LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // receiver side: sample on the rising serial clock while the header is up.
    always @(posedge serial_clk) begin
        if (serial_hdr) begin
            for (int k = 0; k < `DATA_LANES; k++) begin
                mon_lane[k] = {mon_lane[k][`LANE_BITS-2:0], serial_data[k]};
            end
            mon_bits++;
        end
    end

    always @(negedge serial_hdr) begin
        if (rst_n === 1'b1) begin
            if (mon_bits != `LANE_BITS) begin
                errors++;
                $display("FAILED %s header edges: expected %0d, actual %0d",
                         name, `LANE_BITS, mon_bits);
            end
            got_q.push_back(frame_t'(mon_lane));     // lane 0 lands in the top bits.
            frames_seen++;
            mon_bits = 0;
        end
    end

    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_frame(input string tname, input frame_t exp, input frame_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", tname, exp, act);
        end
    endtask

    task automatic check_bit(input string tname, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", tname, exp, act);
        end
    endtask

    task automatic load_request(input int n);
        int b;
        b = n * WORDS;
        req.opcode           = msg_opcode_t'(stim[b][1:0]);
        req.garbage          = stim[b+1][3:0];
        req.piece.piece_type = tile_type_t'(stim[b+2][2:0]);
        req.piece.orient     = orientation_t'(stim[b+3][1:0]);
        req.piece.origin_row = stim[b+4][4:0];
        req.piece.origin_col = stim[b+5][3:0];
        req_valid            = 1'b1;
    endtask

    task automatic send_ack(input logic bit_val);
        ack_valid = 1'b1;
        ack_seq   = bit_val;
        wait_cycle();
        ack_valid = 1'b0;
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        ack_valid = 1'b0;
        ack_seq   = 1'b0;
        mon_lane  = '0;
        mon_bits  = 0;
        errors    = 0;
        cycles    = 0;
        seq       = 1'b0;
        pending   = 1'b0;
        frames_seen = 0;
        void'($urandom(72));
        $readmemh("tests/sender_stimulus.txt", stim);

        repeat (10) wait_cycle();
        rst_n = 1'b1;
        wait_cycle();
        check_bit("reset ready", 1'b1, req_ready);
        check_bit("reset seq", 1'b0, seq_num);
        check_bit("reset hdr", 1'b0, serial_hdr);

        for (int n = 0; n < NUM_TESTS; n++) begin
            name = $sformatf("test %0d", n);
            if (!pending) begin
                repeat ($urandom % 6) wait_cycle();
                load_request(n);
            end
            pending = 1'b0;
            while (!req_ready) wait_cycle();
            wait_cycle();                            // transfer happens at this edge.
            req_valid = 1'b0;

            while (got_q.size() == 0) wait_cycle();
            got_frame     = got_q.pop_front();
            exp_frame     = frame_t'(stim[n*WORDS+6][47:0]);
            exp_frame.seq = seq;
            check_frame(name, exp_frame, got_frame);

            repeat ($urandom % 8) wait_cycle();
            if (stim[n*WORDS+7][0]) begin
                send_ack(~seq);
                wait_cycle();
                check_bit({name, " ready after bad ack"}, 1'b0, req_ready);
                check_bit({name, " seq after bad ack"}, seq, seq_num);
            end
            // odd tests leave the next request waiting on a busy port.
            if (n % 2 == 1 && n + 1 < NUM_TESTS) begin
                load_request(n + 1);
                pending = 1'b1;
                wait_cycle();
                check_bit({name, " ready under back-pressure"}, 1'b0, req_ready);
            end
            send_ack(seq);
            check_bit({name, " ready after ack"}, 1'b1, req_ready);
            check_bit({name, " seq after ack"}, ~seq, seq_num);
            seq = ~seq;
        end

        repeat (4 * `SERIAL_DIV * `LANE_BITS) wait_cycle();
        if (frames_seen != NUM_TESTS || got_q.size() != 0) begin
            errors++;
            $display("FAILED frame count: expected %0d, actual %0d",
                     NUM_TESTS, frames_seen);
        end

        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/sender_stimulus.txt
// columns: opcode garbage piece_type orient origin_row origin_col frame_with_seq_0 bad_ack_first
// all values are hex; the seq bit (45) of the frame is set by the testbench.
3 0 1 0 05 3 C06632990C60 0
0 4 1 1 02 4 0856230D84C0 1
1 0 2 0 00 4 40160A8180A0 0
2 F 3 1 0A 2 9EC35A2CD460 0
3 1 4 2 07 5 C29743A190A0 1
3 0 5 3 03 6 C057238DC6C0 0
3 2 6 2 0C 1 C4E270B4DA40 0
3 0 7 3 0F 7 C1178441DF00 1
3 0 0 0 04 4 C04422110880 0
3 0 3 0 01 0 C02210880220 0
